// ==== logic/core_bus_pkg.sv ====
//////////////////////////////////////////////////
// core datapath and bus geometry
//////////////////////////////////////////////////
package core_bus_pkg;

    localparam int XLEN     = 32;           // scalar / memory word
    localparam int VLEN     = 128;          // one vector register
    localparam int LANES    = VLEN / XLEN;  // elements per vector
    localparam int VREG_NUM = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef word_t [LANES-1:0] vreg_t;      // lane 0 in the low word
    typedef logic [$clog2(VREG_NUM)-1:0] vreg_addr_t;

    localparam word_t PC_INIT = 32'h0000_0000;
    localparam word_t PC_STEP = 32'd4;      // one pair per fetch

    // data port request held stable while the bus holds
    typedef struct packed {
        logic  req;
        logic  we;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic       en;
        vreg_addr_t addr;
        vreg_t      data;
    } vrf_wb_t;

    typedef struct packed {
        logic  valid;
        word_t instr;   // vector instruction
        word_t scalar;  // operand word of the pair
    } fetch_pkt_t;

endpackage

// ==== logic/rvv_isa_pkg.sv ====
//////////////////////////////////////////////////
// vector ISA subset encodings
//////////////////////////////////////////////////
package rvv_isa_pkg;

    import core_bus_pkg::*;

    //////////////////////////////////////////////////
    // major opcodes and function fields
    localparam logic [6:0] OPC_OP_V     = 7'b1010111;
    localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;  // vle*
    localparam logic [6:0] OPC_STORE_FP = 7'b0100111;  // vse*

    localparam logic [2:0] F3_OPIVV = 3'b000;
    localparam logic [2:0] F3_OPMVV = 3'b010;
    localparam logic [2:0] F3_OPIVX = 3'b100;
    localparam logic [2:0] F3_OPMVX = 3'b110;

    localparam logic [5:0] F6_VADD = 6'b000000;
    localparam logic [5:0] F6_VSUB = 6'b000010;
    localparam logic [5:0] F6_VMUL = 6'b100101;  // OPMVV / OPMVX space

    localparam logic [2:0] WIDTH_32 = 3'b110;
    localparam logic [1:0] MOP_UNIT = 2'b00;

    //////////////////////////////////////////////////
    // instruction views
    typedef struct packed {
        logic [5:0] funct6;
        logic       vm;
        vreg_addr_t vs2;
        vreg_addr_t vs1;
        logic [2:0] funct3;
        vreg_addr_t vd;
        logic [6:0] opcode;
    } varith_fmt_t;

    typedef struct packed {
        logic [2:0] nf;
        logic       mew;
        logic [1:0] mop;
        logic       vm;
        logic [4:0] umop;    // lumop / sumop
        logic [4:0] rs1;
        logic [2:0] width;
        vreg_addr_t vd_vs3;  // vd for loads, vs3 for stores
        logic [6:0] opcode;
    } vmem_fmt_t;

    typedef union packed {
        varith_fmt_t arith;
        vmem_fmt_t   mem;
    } vinstr_u;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_MUL
    } alu_op_e;

    typedef struct packed {
        logic       alu_en;
        alu_op_e    alu_op;
        logic       use_scalar;  // .vx form
        logic       mem_load;
        logic       mem_store;
        vreg_addr_t vs1;
        vreg_addr_t vs2;
        vreg_addr_t vd;
        word_t      scalar;      // operand or base address
    } vec_ctrl_t;

endpackage

// ==== logic/fetch_unit.sv ====
//////////////////////////////////////////////////
// fetch stage
//////////////////////////////////////////////////
`timescale 1ns/100ps

module fetch_unit import core_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       bus_hold_i,
    input  logic       exec_hold_i,
    output word_t      pc_addr_o,
    output logic       pc_req_o,
    input  word_t [1:0] pc_data_i,  // [0] instruction, [1] scalar
    output fetch_pkt_t fetch_pkt_o
);

    word_t pc_q;
    logic  req_en_q;     // low for the first cycle out of reset
    logic  valid_q;
    word_t [1:0] pair_q;
    logic  fetch_ok;

    assign pc_req_o = req_en_q & ~exec_hold_i;  // only ask when execute retires
    assign fetch_ok = pc_req_o & ~bus_hold_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q     <= PC_INIT;
            req_en_q <= 1'b0;
            valid_q  <= 1'b0;
        end else begin
            req_en_q <= 1'b1;
            if (!exec_hold_i) begin
                valid_q <= fetch_ok;  // bubble when the bus holds
                if (fetch_ok) begin
                    pc_q <= pc_q + PC_STEP;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_ok) begin
            pair_q <= pc_data_i;
        end
    end

    assign pc_addr_o   = pc_q;
    assign fetch_pkt_o = '{valid: valid_q, instr: pair_q[0], scalar: pair_q[1]};

endmodule

// ==== logic/vec_decoder.sv ====
//////////////////////////////////////////////////
// vector instruction decoder
//////////////////////////////////////////////////
`timescale 1ns/100ps

module vec_decoder import core_bus_pkg::*, rvv_isa_pkg::*; (
    input  fetch_pkt_t fetch_pkt_i,
    output vec_ctrl_t  ctrl_o
);

    vinstr_u instr;

    assign instr = fetch_pkt_i.instr;

    always_comb begin
        ctrl_o = '0;  // no-op unless recognised
        if (fetch_pkt_i.valid) begin
            case (instr.arith.opcode)
                OPC_OP_V: begin
                    ctrl_o.vd = instr.arith.vd;
                    case ({instr.arith.funct3, instr.arith.funct6})
                        {F3_OPIVV, F6_VADD}: ctrl_o.alu_en = 1'b1;
                        {F3_OPIVV, F6_VSUB}: begin
                            ctrl_o.alu_en = 1'b1;
                            ctrl_o.alu_op = ALU_SUB;
                        end
                        {F3_OPMVV, F6_VMUL}: begin
                            ctrl_o.alu_en = 1'b1;
                            ctrl_o.alu_op = ALU_MUL;
                        end
                        {F3_OPIVX, F6_VADD}: begin
                            ctrl_o.alu_en     = 1'b1;
                            ctrl_o.use_scalar = 1'b1;
                        end
                        {F3_OPMVX, F6_VMUL}: begin
                            ctrl_o.alu_en     = 1'b1;
                            ctrl_o.alu_op     = ALU_MUL;
                            ctrl_o.use_scalar = 1'b1;
                        end
                        default: ;
                    endcase
                end
                OPC_LOAD_FP, OPC_STORE_FP: begin
                    // mask bit ignored and base taken from the scalar word
                    ctrl_o.vd = instr.mem.vd_vs3;
                    if (instr.mem.width == WIDTH_32 && instr.mem.mop == MOP_UNIT) begin
                        ctrl_o.mem_load  = (instr.mem.opcode == OPC_LOAD_FP);
                        ctrl_o.mem_store = (instr.mem.opcode == OPC_STORE_FP);
                    end
                end
                default: ;
            endcase

            if (ctrl_o.alu_en || ctrl_o.mem_load || ctrl_o.mem_store) begin
                ctrl_o.vs1    = instr.arith.vs1;
                ctrl_o.vs2    = instr.arith.vs2;
                ctrl_o.scalar = fetch_pkt_i.scalar;
            end else begin
                ctrl_o = '0;
            end
        end
    end

endmodule

// ==== logic/vec_regfile.sv ====
//////////////////////////////////////////////////
// vector register file
//////////////////////////////////////////////////
`timescale 1ns/100ps

module vec_regfile import core_bus_pkg::*, rvv_isa_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  vec_ctrl_t ctrl_i,
    input  vrf_wb_t   alu_wb_i,
    input  vrf_wb_t   lsu_wb_i,
    output vreg_t     vs1_data_o,
    output vreg_t     vs2_data_o,
    output vreg_t     vs3_data_o
);

    vreg_t   regs_q [VREG_NUM];
    vrf_wb_t wb;

    // load unit has priority on the single write port
    assign wb = lsu_wb_i.en ? lsu_wb_i : alu_wb_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < VREG_NUM; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb.en) begin
            regs_q[wb.addr] <= wb.data;
        end
    end

    assign vs1_data_o = regs_q[ctrl_i.vs1];
    assign vs2_data_o = regs_q[ctrl_i.vs2];
    assign vs3_data_o = regs_q[ctrl_i.vd];  // store data

endmodule

// ==== logic/vec_alu.sv ====
//////////////////////////////////////////////////
// four-lane integer ALU
//////////////////////////////////////////////////
`timescale 1ns/100ps

module vec_alu import core_bus_pkg::*, rvv_isa_pkg::*; (
    input  vec_ctrl_t ctrl_i,
    input  vreg_t     vs1_data_i,
    input  vreg_t     vs2_data_i,
    output vrf_wb_t   wb_o
);

    vreg_t opnd;    // vs1 or replicated scalar
    vreg_t result;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            opnd[i] = ctrl_i.use_scalar ? ctrl_i.scalar : vs1_data_i[i];
            case (ctrl_i.alu_op)
                ALU_ADD: result[i] = vs2_data_i[i] + opnd[i];
                ALU_SUB: result[i] = vs2_data_i[i] - opnd[i];  // vs2 - vs1
                ALU_MUL: result[i] = vs2_data_i[i] * opnd[i];  // low word only
                default: result[i] = '0;
            endcase
        end
    end

    // written at the edge closing the execute cycle
    assign wb_o = '{en: ctrl_i.alu_en, addr: ctrl_i.vd, data: result};

endmodule

// ==== logic/vec_lsu.sv ====
//////////////////////////////////////////////////
// vector load / store unit
//////////////////////////////////////////////////
`timescale 1ns/100ps

module vec_lsu import core_bus_pkg::*, rvv_isa_pkg::*; (
    input  logic      clk,
    input  logic      rst_n_i,
    input  vec_ctrl_t ctrl_i,
    input  vreg_t     vs3_data_i,
    input  logic      bus_hold_i,
    output mem_req_t  mem_o,
    input  word_t     mem_rdata_i,
    output vrf_wb_t   wb_o,
    output logic      exec_hold_o
);

    logic [$clog2(LANES)-1:0] beat_q;
    vreg_t load_buf_q;   // lanes collected so far
    vreg_t load_data;
    logic  active;
    logic  accept;
    logic  last;

    assign active = ctrl_i.mem_load | ctrl_i.mem_store;
    assign accept = active & ~bus_hold_i;
    assign last   = (beat_q == LANES - 1);

    //////////////////////////////////////////////////
    // beat counter
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            beat_q <= '0;
        end else if (accept) begin
            beat_q <= beat_q + 1'b1;  // wraps to 0 after the last beat
        end
    end

    always_ff @(posedge clk) begin
        if (accept && ctrl_i.mem_load) begin
            load_buf_q[beat_q] <= mem_rdata_i;
        end
    end

    // request only moves on an accepted beat
    assign mem_o.req   = active;
    assign mem_o.we    = ctrl_i.mem_store;
    assign mem_o.addr  = ctrl_i.scalar + (word_t'(beat_q) << 2);  // base + 4k
    assign mem_o.wdata = vs3_data_i[beat_q];

    //////////////////////////////////////////////////
    // load write-back with the last lane straight from the bus
    always_comb begin
        load_data          = load_buf_q;
        load_data[LANES-1] = mem_rdata_i;
    end

    assign wb_o = '{en: accept & last & ctrl_i.mem_load, addr: ctrl_i.vd, data: load_data};

    assign exec_hold_o = active & ~(accept & last);

endmodule

// ==== logic/riscv_core.sv ====
//////////////////////////////////////////////////
// vector core top
//////////////////////////////////////////////////
`timescale 1ns/100ps

module riscv_core import core_bus_pkg::*, rvv_isa_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    // fetch bus
    output word_t       pc_addr_o,
    output logic        pc_req_o,
    input  word_t [1:0] pc_data_i,  // instruction and scalar pair
    // data bus
    output logic        ex_req_o,
    output logic        ex_we_o,
    output word_t       ex_addr_o,
    output word_t       ex_wdata_o,
    input  word_t       ex_rdata_i,
    input  logic        hold_i      // shared bus hold
);

    fetch_pkt_t fetch_pkt;
    vec_ctrl_t  ctrl;
    vreg_t      vs1_data;
    vreg_t      vs2_data;
    vreg_t      vs3_data;
    vrf_wb_t    alu_wb;
    vrf_wb_t    lsu_wb;
    mem_req_t   ex_req;
    logic       exec_hold;

    assign ex_req_o   = ex_req.req;
    assign ex_we_o    = ex_req.we;
    assign ex_addr_o  = ex_req.addr;
    assign ex_wdata_o = ex_req.wdata;

    fetch_unit u_fetch_unit (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .bus_hold_i  (hold_i),
        .exec_hold_i (exec_hold),
        .pc_addr_o   (pc_addr_o),
        .pc_req_o    (pc_req_o),
        .pc_data_i   (pc_data_i),
        .fetch_pkt_o (fetch_pkt)
    );

    vec_decoder u_vec_decoder (.fetch_pkt_i(fetch_pkt), .ctrl_o(ctrl));

    vec_regfile u_vec_regfile (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .ctrl_i     (ctrl),
        .alu_wb_i   (alu_wb),
        .lsu_wb_i   (lsu_wb),
        .vs1_data_o (vs1_data),
        .vs2_data_o (vs2_data),
        .vs3_data_o (vs3_data)
    );

    vec_alu u_vec_alu (
        .ctrl_i     (ctrl),
        .vs1_data_i (vs1_data),
        .vs2_data_i (vs2_data),
        .wb_o       (alu_wb)
    );

    vec_lsu u_vec_lsu (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .ctrl_i      (ctrl),
        .vs3_data_i  (vs3_data),
        .bus_hold_i  (hold_i),
        .mem_o       (ex_req),
        .mem_rdata_i (ex_rdata_i),
        .wb_o        (lsu_wb),
        .exec_hold_o (exec_hold)
    );

endmodule

// ==== bench/riscv_core_tb.sv ====
//////////////////////////////////////////////////
// vector core testbench
//////////////////////////////////////////////////
`timescale 1ns/100ps

module riscv_core_tb import core_bus_pkg::*; ();

    localparam time CLK_HALF   = 50;
    localparam time DRIVE_DLY  = 10;    // input skew after the rising edge
    localparam int  PAT_DEPTH  = 64;
    localparam int  MEM_WORDS  = 256;   // byte addresses 0x000 to 0x3ff
    localparam int  MAX_CYCLES = 2000;

    logic        clk;
    logic        rst_n_i;
    logic        hold_i;
    word_t       pc_addr_o;
    logic        pc_req_o;
    word_t [1:0] pc_data_i;
    logic        ex_req_o;
    logic        ex_we_o;
    word_t       ex_addr_o;
    word_t       ex_wdata_o;
    word_t       ex_rdata_i;

    logic [67:0] pat [PAT_DEPTH];     // tag nibble then two words
    word_t [1:0] imem [PAT_DEPTH];    // [1] scalar, [0] instruction
    word_t       dmem [MEM_WORDS];
    int          n_instr;
    logic [63:0] exp_q [$];           // {addr, wdata} in acceptance order
    word_t       exp_pc;
    word_t       lcg_state;
    mem_req_t    prev_bus;
    logic        prev_held;           // last cycle had req under hold
    int          cycles;

    // memory answers in the same cycle with zero pairs past the program
    assign pc_data_i  = (pc_addr_o / PC_STEP < n_instr) ? imem[pc_addr_o / PC_STEP] : '0;
    assign ex_rdata_i = dmem[ex_addr_o[9:2]];

    riscv_core riscv_core_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .pc_addr_o  (pc_addr_o),
        .pc_req_o   (pc_req_o),
        .pc_data_i  (pc_data_i),
        .ex_req_o   (ex_req_o),
        .ex_we_o    (ex_we_o),
        .ex_addr_o  (ex_addr_o),
        .ex_wdata_o (ex_wdata_o),
        .ex_rdata_i (ex_rdata_i),
        .hold_i     (hold_i)
    );

    //////////////////////////////////////////////////
    // helpers
    task automatic stop_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input word_t exp, input word_t act);
        $display("** Error: %s expected 0x%08h, got 0x%08h", name, exp, act);
        stop_run();
    endtask

    task automatic plain_error(input string what);
        $display("Error: %s", what);
        stop_run();
    endtask

    function automatic word_t lcg_next(input word_t state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic load_patterns();
        logic [3:0] tag;
        word_t      a;
        word_t      b;
        for (int i = 0; i < PAT_DEPTH; i++) begin
            pat[i] = '0;
        end
        for (int i = 0; i < MEM_WORDS; i++) begin
            dmem[i] = 32'hc0de_0000 ^ word_t'(i << 2);  // fill from the byte address
        end
        $readmemh("bench/core_patterns.txt", pat);
        n_instr = 0;
        for (int i = 0; i < PAT_DEPTH; i++) begin
            {tag, a, b} = pat[i];
            case (tag)
                4'h1: begin
                    imem[n_instr] = {b, a};
                    n_instr++;
                end
                4'h2: dmem[a[9:2]] = b;
                4'h3: exp_q.push_back({a, b});
                default: ;
            endcase
        end
        assert (n_instr != 0 && exp_q.size() != 0)
            else plain_error("pattern file holds no program or no expected store beats");
    endtask

    task automatic check_store();
        logic [63:0] beat;
        assert (exp_q.size() != 0)
            else plain_error("store beat accepted after the last expected one");
        beat = exp_q.pop_front();
        assert (ex_addr_o == beat[63:32])
            else value_error("ex_addr_o", beat[63:32], ex_addr_o);
        assert (ex_wdata_o == beat[31:0])
            else value_error("ex_wdata_o", beat[31:0], ex_wdata_o);
        dmem[ex_addr_o[9:2]] = ex_wdata_o;
    endtask

    //////////////////////////////////////////////////
    // clock, hold generator and monitor
    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst_n_i) begin
            #DRIVE_DLY;
            lcg_state = lcg_next(lcg_state);
            hold_i    = (lcg_state[31:30] == 2'b00);  // about one cycle in four
        end
    end

    // sampled mid-cycle where all bus signals are settled
    always @(negedge clk) begin
        if (!rst_n_i) begin
            assert (!pc_req_o)
                else value_error("pc_req_o", 32'h0, word_t'(pc_req_o));
            assert (!ex_req_o)
                else value_error("ex_req_o", 32'h0, word_t'(ex_req_o));
            assert (!ex_we_o)
                else value_error("ex_we_o", 32'h0, word_t'(ex_we_o));
            assert (pc_addr_o == PC_INIT)
                else value_error("pc_addr_o", PC_INIT, pc_addr_o);
            prev_held = 1'b0;
        end else begin
            if (pc_req_o && !hold_i) begin
                assert (pc_addr_o == exp_pc)
                    else value_error("pc_addr_o", exp_pc, pc_addr_o);
                exp_pc = exp_pc + PC_STEP;
            end
            if (prev_held) begin
                assert (ex_req_o)
                    else value_error("ex_req_o", 32'h1, word_t'(ex_req_o));
                assert (ex_we_o == prev_bus.we)
                    else value_error("ex_we_o", word_t'(prev_bus.we), word_t'(ex_we_o));
                assert (ex_addr_o == prev_bus.addr)
                    else value_error("ex_addr_o", prev_bus.addr, ex_addr_o);
                assert (ex_wdata_o == prev_bus.wdata)
                    else value_error("ex_wdata_o", prev_bus.wdata, ex_wdata_o);
            end
            if (ex_req_o && ex_we_o && !hold_i) begin
                check_store();
            end
            prev_held = ex_req_o & hold_i;
            prev_bus  = '{req: ex_req_o, we: ex_we_o, addr: ex_addr_o, wdata: ex_wdata_o};
        end
    end

    //////////////////////////////////////////////////
    // main sequence
    initial begin
        rst_n_i   = 1'b0;
        hold_i    = 1'b0;
        lcg_state = 32'hc832_5632;
        exp_pc    = PC_INIT;
        prev_held = 1'b0;
        prev_bus  = '0;
        cycles    = 0;
        load_patterns();
        repeat (4) @(posedge clk);
        #DRIVE_DLY rst_n_i = 1'b1;

        while (exp_q.size() != 0 && cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            plain_error("timed out waiting for the expected store beats");
        end else begin
            repeat (20) @(posedge clk);  // room for a stray store
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// ==== bench/core_patterns.txt ====
// record = tag_a_b, tag 1: fetch pair (instruction, scalar word)
// tag 2: initial data word (address, value), tag 3: expected store beat (address, wdata)
2_00000100_00000005
2_00000104_00001000
2_00000108_FFFFFFFE
2_0000010C_00010003
1_02006087_00000100  // vle32.v v1, base 0x100
1_02104157_00000011  // vadd.vx v2, v1, 0x11
1_020060A7_00000200  // vse32.v v1, base 0x200
1_022081D7_00000000  // vadd.vv v3, v2, v1
1_0A308257_00000000  // vsub.vv v4, v3, v1
1_9640A2D7_00000000  // vmul.vv v5, v4, v1
1_96506357_00000003  // vmul.vx v6, v5, 3
1_02006127_00000210  // vse32.v v2, base 0x210
1_020061A7_00000220  // vse32.v v3, base 0x220
1_02006327_00000230  // vse32.v v6, base 0x230
3_00000200_00000005
3_00000204_00001000
3_00000208_FFFFFFFE
3_0000020C_00010003
3_00000210_00000016
3_00000214_00001011
3_00000218_0000000F
3_0000021C_00010014
3_00000220_0000001B
3_00000224_00002011
3_00000228_0000000D
3_0000022C_00020017
3_00000230_0000014A
3_00000234_03033000
3_00000238_FFFFFFA6
3_0000023C_004500B4

// ==== project.f ====
logic/core_bus_pkg.sv
logic/rvv_isa_pkg.sv
logic/fetch_unit.sv
logic/vec_decoder.sv
logic/vec_regfile.sv
logic/vec_alu.sv
logic/vec_lsu.sv
logic/riscv_core.sv
bench/riscv_core_tb.sv

// ==== Bender.yml ====
package:
  name: riscv_core

sources:
  - files:
      - logic/core_bus_pkg.sv
      - logic/rvv_isa_pkg.sv
      - logic/fetch_unit.sv
      - logic/vec_decoder.sv
      - logic/vec_regfile.sv
      - logic/vec_alu.sv
      - logic/vec_lsu.sv
      - logic/riscv_core.sv
  - target: simulation
    files:
      - bench/riscv_core_tb.sv
